/* common/lc3b_config.svh */
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// address of the first instruction fetched after reset.
`define LC3B_RESET_PC 16'h0000

// byte address width of the wishbone master port.
`define LC3B_WB_AW 16

`endif

/* common/lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

	// lc-3b major opcodes, instruction bits 15 to 12.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode_t;

	typedef enum logic [2:0] {
		alu_add, alu_and, alu_not, alu_pass, alu_sll, alu_srl, alu_sra
	} lc3b_aluop_t;

	typedef enum logic [1:0] {pc_next, pc_branch, pc_reg, pc_jsr} lc3b_pcsel_t;

	typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc, wb_lea} lc3b_wbsel_t;

	typedef enum logic [1:0] {b_reg, b_imm5, b_off6, b_shamt} lc3b_alubsel_t;

	typedef enum logic [2:0] {
		st_fetch, st_decode, st_execute, st_mem, st_writeback
	} lc3b_state_t;

endpackage

`default_nettype wire

/* decode/gen_control.sv */
`timescale 1ns/1ns
`default_nettype none

module gen_control (
	input  lc3b_pkg::lc3b_opcode_t  opcode,
	input  logic [11:0]             ir_bits,
	output lc3b_pkg::lc3b_aluop_t   alu_op,
	output lc3b_pkg::lc3b_alubsel_t alu_b_sel,
	output lc3b_pkg::lc3b_pcsel_t   pc_sel,
	output lc3b_pkg::lc3b_wbsel_t   wb_sel_src,
	output logic                    reg_load,
	output logic                    cc_load,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic                    dest_r7,
	output logic                    sr1_is_dest
);

	always_comb begin
		// defaults give no write and pc plus 2.
		alu_op      = lc3b_pkg::alu_add;
		alu_b_sel   = lc3b_pkg::b_reg;
		pc_sel      = lc3b_pkg::pc_next;
		wb_sel_src  = lc3b_pkg::wb_alu;
		reg_load    = 1'b0;
		cc_load     = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		dest_r7     = 1'b0;
		sr1_is_dest = 1'b0;

		case (opcode)
			lc3b_pkg::op_add: begin
				reg_load = 1'b1;
				cc_load  = 1'b1;
				if (ir_bits[5]) begin
					alu_b_sel = lc3b_pkg::b_imm5;
				end
			end
			lc3b_pkg::op_and: begin
				alu_op   = lc3b_pkg::alu_and;
				reg_load = 1'b1;
				cc_load  = 1'b1;
				if (ir_bits[5]) begin
					alu_b_sel = lc3b_pkg::b_imm5;
				end
			end
			lc3b_pkg::op_not: begin
				alu_op   = lc3b_pkg::alu_not;
				reg_load = 1'b1;
				cc_load  = 1'b1;
			end
			lc3b_pkg::op_shf: begin
				alu_b_sel = lc3b_pkg::b_shamt;
				reg_load  = 1'b1;
				cc_load   = 1'b1;
				// bit 4 picks the direction, bit 5 arithmetic for right shifts.
				if (!ir_bits[4]) begin
					alu_op = lc3b_pkg::alu_sll;
				end else if (!ir_bits[5]) begin
					alu_op = lc3b_pkg::alu_srl;
				end else begin
					alu_op = lc3b_pkg::alu_sra;
				end
			end
			lc3b_pkg::op_lea: begin
				wb_sel_src = lc3b_pkg::wb_lea;
				reg_load   = 1'b1;
			end
			lc3b_pkg::op_br: begin
				pc_sel = lc3b_pkg::pc_branch;
			end
			lc3b_pkg::op_jmp: begin
				alu_op = lc3b_pkg::alu_pass;
				pc_sel = lc3b_pkg::pc_reg;
			end
			lc3b_pkg::op_jsr: begin
				// return address goes to r7 in both forms.
				wb_sel_src = lc3b_pkg::wb_pc;
				reg_load   = 1'b1;
				dest_r7    = 1'b1;
				if (ir_bits[11]) begin
					pc_sel = lc3b_pkg::pc_jsr;
				end else begin
					alu_op = lc3b_pkg::alu_pass;
					pc_sel = lc3b_pkg::pc_reg;
				end
			end
			lc3b_pkg::op_ldr: begin
				alu_b_sel  = lc3b_pkg::b_off6;
				wb_sel_src = lc3b_pkg::wb_mem;
				mem_read   = 1'b1;
				reg_load   = 1'b1;
				cc_load    = 1'b1;
			end
			lc3b_pkg::op_str: begin
				alu_b_sel   = lc3b_pkg::b_off6;
				mem_write   = 1'b1;
				sr1_is_dest = 1'b1;
			end
			default: begin
				// byte access, indirect, trap and rti behave as no-ops.
			end
		endcase
	end

endmodule

`default_nettype wire

/* datapath/lc3b_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_alu (
	input  lc3b_pkg::lc3b_aluop_t alu_op,
	input  logic [15:0]           a,
	input  logic [15:0]           b,
	output logic [15:0]           y
);

	logic [3:0] shamt;

	// shifts use only the low nibble of b.
	assign shamt = b[3:0];

	always_comb begin
		case (alu_op)
			lc3b_pkg::alu_add: begin
				y = a + b;
			end
			lc3b_pkg::alu_and: begin
				y = a & b;
			end
			lc3b_pkg::alu_not: begin
				y = ~a;
			end
			lc3b_pkg::alu_pass: begin
				y = a;
			end
			lc3b_pkg::alu_sll: begin
				y = a << shamt;
			end
			lc3b_pkg::alu_srl: begin
				y = a >> shamt;
			end
			lc3b_pkg::alu_sra: begin
				y = $unsigned($signed(a) >>> shamt);
			end
			default: begin
				y = a;
			end
		endcase
	end

endmodule

`default_nettype wire

/* datapath/lc3b_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_regfile (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [2:0]  rd_addr1,
	input  logic [2:0]  rd_addr2,
	input  logic [2:0]  wr_addr,
	input  logic [15:0] wr_data,
	input  logic        wr_en,
	output logic [15:0] rd_data1,
	output logic [15:0] rd_data2
);

	logic [15:0] regs [8];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= 16'h0000;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// reads see the old value during a write cycle.
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

`default_nettype wire

/* verilog/lc3b_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "lc3b_config.svh"

module lc3b_sequencer (
	input  logic                      clk,
	input  logic                      arst_n,
	input  lc3b_pkg::lc3b_aluop_t     alu_op,
	input  lc3b_pkg::lc3b_alubsel_t   alu_b_sel,
	input  lc3b_pkg::lc3b_pcsel_t     pc_sel,
	input  lc3b_pkg::lc3b_wbsel_t     wb_sel_src,
	input  logic                      reg_load,
	input  logic                      cc_load,
	input  logic                      mem_read,
	input  logic                      mem_write,
	input  logic                      dest_r7,
	input  logic                      sr1_is_dest,
	input  logic [15:0]               rd_data1,
	input  logic [15:0]               rd_data2,
	input  logic [15:0]               alu_y,
	input  logic [15:0]               wb_dat_i,
	input  logic                      wb_ack,
	output lc3b_pkg::lc3b_opcode_t    opcode,
	output logic [11:0]               ir_bits,
	output logic [2:0]                rd_addr1,
	output logic [2:0]                rd_addr2,
	output logic [2:0]                wr_addr,
	output logic [15:0]               wr_data,
	output logic                      wr_en,
	output lc3b_pkg::lc3b_aluop_t     ex_alu_op,
	output logic [15:0]               alu_a,
	output logic [15:0]               alu_b,
	output logic [`LC3B_WB_AW-1:0]    wb_adr,
	output logic [15:0]               wb_dat_o,
	output logic                      wb_we,
	output logic [1:0]                wb_sel,
	output logic                      wb_cyc,
	output logic                      wb_stb
);

	lc3b_pkg::lc3b_state_t   state;
	lc3b_pkg::lc3b_alubsel_t alu_b_sel_q;
	lc3b_pkg::lc3b_pcsel_t   pc_sel_q;
	lc3b_pkg::lc3b_wbsel_t   wb_sel_src_q;
	logic        reg_load_q, cc_load_q, mem_read_q, mem_write_q, dest_r7_q, sr1_is_dest_q;
	logic [15:0] pc, ir, mar, mdr, res;
	logic [2:0]  cc;
	logic        bus_req;
	logic [15:0] pc_plus2, off9, off11, off6, imm5, br_target, next_pc;
	logic        br_taken;

	assign opcode  = lc3b_pkg::lc3b_opcode_t'(ir[15:12]);
	assign ir_bits = ir[11:0];

	// sign-extended immediates, offsets in words become byte offsets.
	assign off9      = {{6{ir[8]}}, ir[8:0], 1'b0};
	assign off11     = {{4{ir[10]}}, ir[10:0], 1'b0};
	assign off6      = {{9{ir[5]}}, ir[5:0], 1'b0};
	assign imm5      = {{11{ir[4]}}, ir[4:0]};
	assign pc_plus2  = pc + 16'd2;
	assign br_target = pc_plus2 + off9;
	assign br_taken  = |(ir[11:9] & cc);

	// str reads its source on port 1 and the base on port 2.
	assign rd_addr1 = sr1_is_dest_q ? ir[11:9] : ir[8:6];
	assign rd_addr2 = sr1_is_dest_q ? ir[8:6] : ir[2:0];
	assign alu_a    = sr1_is_dest_q ? rd_data2 : rd_data1;

	always_comb begin
		case (alu_b_sel_q)
			lc3b_pkg::b_imm5:  alu_b = imm5;
			lc3b_pkg::b_off6:  alu_b = off6;
			lc3b_pkg::b_shamt: alu_b = {12'h000, ir[3:0]};
			default:           alu_b = rd_data2;
		endcase
	end

	always_comb begin
		case (wb_sel_src_q)
			lc3b_pkg::wb_mem: wr_data = mdr;
			lc3b_pkg::wb_pc:  wr_data = pc_plus2;
			lc3b_pkg::wb_lea: wr_data = br_target;
			default:          wr_data = res;
		endcase
	end

	always_comb begin
		case (pc_sel_q)
			lc3b_pkg::pc_branch: next_pc = br_taken ? br_target : pc_plus2;
			lc3b_pkg::pc_reg:    next_pc = res;
			lc3b_pkg::pc_jsr:    next_pc = pc_plus2 + off11;
			default:             next_pc = pc_plus2;
		endcase
	end

	assign wr_addr = dest_r7_q ? 3'd7 : ir[11:9];
	assign wr_en   = (state == lc3b_pkg::st_writeback) && reg_load_q;

	// bus outputs; the address is the pc unless a data access is open.
	assign wb_adr   = (state == lc3b_pkg::st_mem) ? mar : pc;
	assign wb_dat_o = mdr;
	assign wb_we    = (state == lc3b_pkg::st_mem) && mem_write_q;
	assign wb_sel   = 2'b11;
	assign wb_cyc   = bus_req;
	assign wb_stb   = bus_req;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= lc3b_pkg::st_fetch;
			pc            <= `LC3B_RESET_PC;
			cc            <= 3'b010;
			bus_req       <= 1'b0;
			ex_alu_op     <= lc3b_pkg::alu_add;
			alu_b_sel_q   <= lc3b_pkg::b_reg;
			pc_sel_q      <= lc3b_pkg::pc_next;
			wb_sel_src_q  <= lc3b_pkg::wb_alu;
			reg_load_q    <= 1'b0;
			cc_load_q     <= 1'b0;
			mem_read_q    <= 1'b0;
			mem_write_q   <= 1'b0;
			dest_r7_q     <= 1'b0;
			sr1_is_dest_q <= 1'b0;
		end else begin
			case (state)
				lc3b_pkg::st_fetch: begin
					// only the first fetch after reset opens its own cycle.
					if (!bus_req) begin
						bus_req <= 1'b1;
					end else if (wb_ack) begin
						bus_req <= 1'b0;
						state   <= lc3b_pkg::st_decode;
					end
				end
				lc3b_pkg::st_decode: begin
					ex_alu_op     <= alu_op;
					alu_b_sel_q   <= alu_b_sel;
					pc_sel_q      <= pc_sel;
					wb_sel_src_q  <= wb_sel_src;
					reg_load_q    <= reg_load;
					cc_load_q     <= cc_load;
					mem_read_q    <= mem_read;
					mem_write_q   <= mem_write;
					dest_r7_q     <= dest_r7;
					sr1_is_dest_q <= sr1_is_dest;
					state         <= lc3b_pkg::st_execute;
				end
				lc3b_pkg::st_execute: begin
					if (mem_read_q || mem_write_q) begin
						bus_req <= 1'b1;
						state   <= lc3b_pkg::st_mem;
					end else begin
						state <= lc3b_pkg::st_writeback;
					end
				end
				lc3b_pkg::st_mem: begin
					if (wb_ack) begin
						bus_req <= 1'b0;
						state   <= lc3b_pkg::st_writeback;
					end
				end
				lc3b_pkg::st_writeback: begin
					pc <= next_pc;
					if (cc_load_q) begin
						cc <= {wr_data[15], wr_data == 16'h0000,
							!wr_data[15] && (wr_data != 16'h0000)};
					end
					// next fetch starts straight away from the new pc.
					bus_req <= 1'b1;
					state   <= lc3b_pkg::st_fetch;
				end
				default: begin
					bus_req <= 1'b0;
					state   <= lc3b_pkg::st_fetch;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == lc3b_pkg::st_fetch && bus_req && wb_ack) begin
			ir <= wb_dat_i;
		end
		if (state == lc3b_pkg::st_execute) begin
			if (mem_read_q || mem_write_q) begin
				mar <= alu_y;
			end else begin
				res <= alu_y;
			end
			if (mem_write_q) begin
				mdr <= rd_data1;
			end
		end
		if (state == lc3b_pkg::st_mem && wb_ack && !mem_write_q) begin
			mdr <= wb_dat_i;
		end
	end

endmodule

`default_nettype wire

/* verilog/lc3b_core.sv */
`timescale 1ns/1ns
`default_nettype none
`include "lc3b_config.svh"

module lc3b_core (
	input  logic                   clk,
	input  logic                   arst_n,
	output logic [`LC3B_WB_AW-1:0] wb_adr,
	output logic [15:0]            wb_dat_o,
	input  logic [15:0]            wb_dat_i,
	output logic                   wb_we,
	output logic [1:0]             wb_sel,
	output logic                   wb_cyc,
	output logic                   wb_stb,
	input  logic                   wb_ack
);

	lc3b_pkg::lc3b_opcode_t  opcode;
	lc3b_pkg::lc3b_aluop_t   dec_alu_op, ex_alu_op;
	lc3b_pkg::lc3b_alubsel_t alu_b_sel;
	lc3b_pkg::lc3b_pcsel_t   pc_sel;
	lc3b_pkg::lc3b_wbsel_t   wb_sel_src;
	logic        reg_load, cc_load, mem_read, mem_write, dest_r7, sr1_is_dest;
	logic [11:0] ir_bits;
	logic [2:0]  rd_addr1, rd_addr2, wr_addr;
	logic [15:0] rd_data1, rd_data2, wr_data;
	logic        wr_en;
	logic [15:0] alu_a, alu_b, alu_y;

	gen_control u_gen_control (
		.opcode(opcode), .ir_bits(ir_bits), .alu_op(dec_alu_op), .alu_b_sel(alu_b_sel),
		.pc_sel(pc_sel), .wb_sel_src(wb_sel_src), .reg_load(reg_load), .cc_load(cc_load),
		.mem_read(mem_read), .mem_write(mem_write), .dest_r7(dest_r7),
		.sr1_is_dest(sr1_is_dest)
	);

	lc3b_sequencer u_sequencer (
		.clk(clk), .arst_n(arst_n), .alu_op(dec_alu_op), .alu_b_sel(alu_b_sel),
		.pc_sel(pc_sel), .wb_sel_src(wb_sel_src), .reg_load(reg_load), .cc_load(cc_load),
		.mem_read(mem_read), .mem_write(mem_write), .dest_r7(dest_r7),
		.sr1_is_dest(sr1_is_dest), .rd_data1(rd_data1), .rd_data2(rd_data2),
		.alu_y(alu_y), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack), .opcode(opcode),
		.ir_bits(ir_bits), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2), .wr_addr(wr_addr),
		.wr_data(wr_data), .wr_en(wr_en), .ex_alu_op(ex_alu_op), .alu_a(alu_a),
		.alu_b(alu_b), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_we(wb_we),
		.wb_sel(wb_sel), .wb_cyc(wb_cyc), .wb_stb(wb_stb)
	);

	lc3b_regfile u_regfile (
		.clk(clk), .arst_n(arst_n), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.wr_addr(wr_addr), .wr_data(wr_data), .wr_en(wr_en),
		.rd_data1(rd_data1), .rd_data2(rd_data2)
	);

	lc3b_alu u_alu (
		.alu_op(ex_alu_op), .a(alu_a), .b(alu_b), .y(alu_y)
	);

endmodule

`default_nettype wire

/* bench/lc3b_core_assertions.sv */
`timescale 1ns/1ns
`default_nettype none
`include "lc3b_config.svh"

module lc3b_core_assertions (
	input logic                   clk,
	input logic                   arst_n,
	input logic [`LC3B_WB_AW-1:0] wb_adr,
	input logic [15:0]            wb_dat_o,
	input logic                   wb_we,
	input logic                   wb_cyc,
	input logic                   wb_stb,
	input logic                   wb_ack
);

	// a strobe is only valid inside a bus cycle.
	stb_needs_cyc: assert property (@(posedge clk) wb_stb |-> wb_cyc)
		else $error("wishbone stb high without cyc");

	// master holds the request until the slave acks.
	stb_held: assert property (@(posedge clk) disable iff (!arst_n)
		(wb_stb && !wb_ack) |=> wb_stb)
		else $error("wishbone stb dropped before ack");

	request_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_o) && $stable(wb_we)))
		else $error("wishbone address, data or we changed during a wait state");

	no_cyc_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_cyc)
		else $error("wishbone cyc high during reset");

endmodule

`default_nettype wire

/* bench/lc3b_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "lc3b_config.svh"

module lc3b_core_tb;

	localparam int clk_period   = 10;
	localparam int reset_cycles = 10;
	localparam int prog_len     = 45;
	localparam int store_count  = 13;
	localparam int watchdog_ns  = (reset_cycles + prog_len * 12) * clk_period;
	localparam logic [15:0] halt_addr = 16'h0058;

	logic                   clk;
	logic                   arst_n;
	logic [`LC3B_WB_AW-1:0] wb_adr;
	logic [15:0]            wb_dat_o;
	logic [15:0]            wb_dat_i;
	logic                   wb_we;
	logic [1:0]             wb_sel;
	logic                   wb_cyc;
	logic                   wb_stb;
	logic                   wb_ack;

	logic [15:0] mem [64];
	logic [15:0] lfsr_state   = 16'd99;
	logic [1:0]  wait_left    = 2'd0;
	logic        in_transfer  = 1'b0;
	int          store_idx    = 0;
	int          halt_fetches = 0;

	// instruction words, entry i sits at byte address 2i.
	logic [15:0] program_words [prog_len] = '{
		// lea r6 to 0x60, add imm, add imm negative, add reg, str.
		16'hEC2F, 16'h1267, 16'h14BD, 16'h1642, 16'h7780,
		// and reg, str, and imm, str, not, str.
		16'h5881, 16'h7981, 16'h5ABC, 16'h7B82, 16'h967F, 16'h7783,
		// sll, str, srl, str, sra, str.
		16'hD684, 16'h7784, 16'hD894, 16'h7985, 16'hDAF3, 16'h7B86,
		// ldr from 0x7e and store of the loaded word.
		16'h638F, 16'h7387,
		// brz not taken, brn taken over a store.
		16'h0401, 16'h0801, 16'h738D,
		// and to zero, brnp not taken, brz taken over a store.
		16'h5920, 16'h0A01, 16'h0401, 16'h738D,
		// add to positive, brp taken over a store, str.
		16'h1929, 16'h0201, 16'h738D, 16'h7988,
		// jsr, str r7 on return, br past the subroutine, dead store.
		16'h4803, 16'h7F89, 16'h0E04, 16'h738D,
		// first subroutine does lea r5, str and jmp r7.
		16'hEA05, 16'h7B8A, 16'hC1C0,
		// lea r2 to the second subroutine, jsrr r2, str r7, br to halt.
		16'hE404, 16'h4080, 16'h7F8B, 16'h0E03, 16'h738D,
		// second subroutine does str r2 and jmp r7, then the self-branch.
		16'h758C, 16'hC1C0, 16'h0FFF
	};

	// stores in the order the program makes them.
	logic [15:0] exp_store_addr [store_count] = '{
		16'h0060, 16'h0062, 16'h0064, 16'h0066, 16'h0068, 16'h006A, 16'h006C,
		16'h006E, 16'h0070, 16'h0074, 16'h0072, 16'h0078, 16'h0076
	};
	logic [15:0] exp_store_data [store_count] = '{
		16'h0004, 16'h0005, 16'hFFFC, 16'hFFF8, 16'hFFD0, 16'h0FFF, 16'hFFFA,
		16'hA5C3, 16'h0009, 16'h0050, 16'h003E, 16'h0054, 16'h004E
	};

	lc3b_core UUT (
		.clk(clk), .arst_n(arst_n), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o),
		.wb_dat_i(wb_dat_i), .wb_we(wb_we), .wb_sel(wb_sel), .wb_cyc(wb_cyc),
		.wb_stb(wb_stb), .wb_ack(wb_ack)
	);

	bind lc3b_core lc3b_core_assertions u_wb_assertions (
		.clk(clk), .arst_n(arst_n), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o),
		.wb_we(wb_we), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack)
	);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_wait_states(output logic [1:0] count);
		for (int k = 0; k < 2; k++) begin
			count = {count[0], lfsr_state[15]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic fail_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_addr(input logic [`LC3B_WB_AW-1:0] expected,
		input logic [`LC3B_WB_AW-1:0] actual, input string name);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_data(input logic [15:0] expected, input logic [15:0] actual,
		input string name);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_sel(input logic [1:0] expected, input logic [1:0] actual,
		input string name);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
			fail_run();
		end
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	// slave model acks after 0 to 3 wait states.
	always @(posedge clk) begin
		#1;
		if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!in_transfer) begin
				draw_wait_states(wait_left);
				in_transfer = 1'b1;
			end
			if (wait_left == 2'd0) begin
				wb_ack      = 1'b1;
				in_transfer = 1'b0;
				if (wb_we) begin
					mem[wb_adr[6:1]] = wb_dat_o;
				end else begin
					wb_dat_i = mem[wb_adr[6:1]];
				end
			end else begin
				wait_left = wait_left - 2'd1;
			end
		end
	end

	// completed transfers are checked mid-cycle.
	always @(negedge clk) begin
		if (wb_cyc && wb_stb && wb_ack) begin
			if (wb_adr[`LC3B_WB_AW-1:7] != '0) begin
				$display("bus access at %h lies outside the 64-word memory", wb_adr);
				fail_run();
			end else begin
				// every access moves a whole word.
				check_sel(2'b11, wb_sel, "wb_sel");
				if (wb_we) begin
					if (store_idx >= store_count) begin
						$display("store to %h with %h was not expected", wb_adr, wb_dat_o);
						fail_run();
					end else begin
						check_addr(exp_store_addr[store_idx[3:0]], wb_adr, "wb_adr");
						check_data(exp_store_data[store_idx[3:0]], wb_dat_o, "wb_dat_o");
						store_idx = store_idx + 1;
					end
				end else if (wb_adr == halt_addr) begin
					halt_fetches = halt_fetches + 1;
				end
			end
		end
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired before the program reached its final self-branch");
		fail_run();
	end

	initial begin
		arst_n   = 1'b0;
		wb_ack   = 1'b0;
		wb_dat_i = 16'h0000;
		for (int a = 0; a < 64; a++) begin
			mem[a[5:0]] = 16'hF000 | {9'd0, a[5:0], 1'b0};
		end
		// data word read by the ldr at 0x7e.
		mem[63] = 16'hA5C3;
		for (int i = 0; i < prog_len; i++) begin
			mem[i[5:0]] = program_words[i[5:0]];
		end
		repeat (reset_cycles) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// two fetches of the halt word mean the self-branch was taken.
		wait (halt_fetches >= 2);
		if (store_idx == store_count) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("program halted after %0d of %0d stores", store_idx, store_count);
			fail_run();
		end
	end

endmodule

`default_nettype wire

/* lc3b_core.f */
+incdir+common
common/lc3b_pkg.sv
decode/gen_control.sv
datapath/lc3b_alu.sv
datapath/lc3b_regfile.sv
verilog/lc3b_sequencer.sv
verilog/lc3b_core.sv
bench/lc3b_core_assertions.sv
bench/lc3b_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the LC-3b core testbench with Verilator and run it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module lc3b_core_tb \
	-f lc3b_core.f \
	-Mdir obj_dir -o lc3b_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/lc3b_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
